//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int OPCODE_W    = 17; // major opcode, funct3, funct7
    localparam int SHAMT_W     = 5;
    localparam int STRB_W      = 4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [STRB_W-1:0] STRB_BYTE = 4'b0001;
    localparam logic [STRB_W-1:0] STRB_HALF = 4'b0011;
    localparam logic [STRB_W-1:0] STRB_WORD = 4'b1111;

    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4; // return address step

    typedef enum logic [5:0] {
        op_nop,
        // register forms
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        // immediate forms
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        op_lui, op_auipc,
        op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw
    } op_e;

endpackage

`default_nettype wire

//--- verilog/exec_latch.sv
`timescale 1ns/1ps
`default_nettype none

module exec_latch (
    input  wire                               CLK,
    input  wire                               rst,
    input  wire                               flush,
    input  wire                               stall,
    input  wire                               mem_wait,
    input  wire  [exec_pkg::XLEN-1:0]         pc,
    input  wire  [exec_pkg::OPCODE_W-1:0]     opcode,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]   rd_addr,
    input  wire  [exec_pkg::XLEN-1:0]         rs1_data,
    input  wire  [exec_pkg::XLEN-1:0]         rs2_data,
    input  wire  [exec_pkg::XLEN-1:0]         imm,
    output exec_pkg::op_e                     op,
    output logic [exec_pkg::XLEN-1:0]         pc_q,
    output logic [exec_pkg::REG_ADDR_W-1:0]   rd_q,
    output logic [exec_pkg::XLEN-1:0]         rs1_q,
    output logic [exec_pkg::XLEN-1:0]         rs2_q,
    output logic [exec_pkg::XLEN-1:0]         imm_q
);

    exec_pkg::op_e op_dec;

    always_comb begin
        casez (opcode)
            {exec_pkg::OPC_OP, 3'b000, 7'b0000000}:     op_dec = exec_pkg::op_add;
            {exec_pkg::OPC_OP, 3'b000, 7'b0100000}:     op_dec = exec_pkg::op_sub;
            {exec_pkg::OPC_OP, 3'b111, 7'b0000000}:     op_dec = exec_pkg::op_and;
            {exec_pkg::OPC_OP, 3'b110, 7'b0000000}:     op_dec = exec_pkg::op_or;
            {exec_pkg::OPC_OP, 3'b100, 7'b0000000}:     op_dec = exec_pkg::op_xor;
            {exec_pkg::OPC_OP, 3'b001, 7'b0000000}:     op_dec = exec_pkg::op_sll;
            {exec_pkg::OPC_OP, 3'b101, 7'b0000000}:     op_dec = exec_pkg::op_srl;
            {exec_pkg::OPC_OP, 3'b101, 7'b0100000}:     op_dec = exec_pkg::op_sra;
            {exec_pkg::OPC_OP, 3'b010, 7'b0000000}:     op_dec = exec_pkg::op_slt;
            {exec_pkg::OPC_OP, 3'b011, 7'b0000000}:     op_dec = exec_pkg::op_sltu;
            {exec_pkg::OPC_OP_IMM, 3'b000, 7'b???????}: op_dec = exec_pkg::op_addi;
            {exec_pkg::OPC_OP_IMM, 3'b111, 7'b???????}: op_dec = exec_pkg::op_andi;
            {exec_pkg::OPC_OP_IMM, 3'b110, 7'b???????}: op_dec = exec_pkg::op_ori;
            {exec_pkg::OPC_OP_IMM, 3'b100, 7'b???????}: op_dec = exec_pkg::op_xori;
            {exec_pkg::OPC_OP_IMM, 3'b001, 7'b0000000}: op_dec = exec_pkg::op_slli;
            {exec_pkg::OPC_OP_IMM, 3'b101, 7'b0000000}: op_dec = exec_pkg::op_srli;
            {exec_pkg::OPC_OP_IMM, 3'b101, 7'b0100000}: op_dec = exec_pkg::op_srai;
            {exec_pkg::OPC_OP_IMM, 3'b010, 7'b???????}: op_dec = exec_pkg::op_slti;
            {exec_pkg::OPC_OP_IMM, 3'b011, 7'b???????}: op_dec = exec_pkg::op_sltiu;
            {exec_pkg::OPC_LUI, 3'b???, 7'b???????}:    op_dec = exec_pkg::op_lui;
            {exec_pkg::OPC_AUIPC, 3'b???, 7'b???????}:  op_dec = exec_pkg::op_auipc;
            {exec_pkg::OPC_JAL, 3'b???, 7'b???????}:    op_dec = exec_pkg::op_jal;
            {exec_pkg::OPC_JALR, 3'b000, 7'b???????}:   op_dec = exec_pkg::op_jalr;
            {exec_pkg::OPC_BRANCH, 3'b000, 7'b???????}: op_dec = exec_pkg::op_beq;
            {exec_pkg::OPC_BRANCH, 3'b001, 7'b???????}: op_dec = exec_pkg::op_bne;
            {exec_pkg::OPC_BRANCH, 3'b100, 7'b???????}: op_dec = exec_pkg::op_blt;
            {exec_pkg::OPC_BRANCH, 3'b101, 7'b???????}: op_dec = exec_pkg::op_bge;
            {exec_pkg::OPC_BRANCH, 3'b110, 7'b???????}: op_dec = exec_pkg::op_bltu;
            {exec_pkg::OPC_BRANCH, 3'b111, 7'b???????}: op_dec = exec_pkg::op_bgeu;
            {exec_pkg::OPC_LOAD, 3'b000, 7'b???????}:   op_dec = exec_pkg::op_lb;
            {exec_pkg::OPC_LOAD, 3'b001, 7'b???????}:   op_dec = exec_pkg::op_lh;
            {exec_pkg::OPC_LOAD, 3'b010, 7'b???????}:   op_dec = exec_pkg::op_lw;
            {exec_pkg::OPC_LOAD, 3'b100, 7'b???????}:   op_dec = exec_pkg::op_lbu;
            {exec_pkg::OPC_LOAD, 3'b101, 7'b???????}:   op_dec = exec_pkg::op_lhu;
            {exec_pkg::OPC_STORE, 3'b000, 7'b???????}:  op_dec = exec_pkg::op_sb;
            {exec_pkg::OPC_STORE, 3'b001, 7'b???????}:  op_dec = exec_pkg::op_sh;
            {exec_pkg::OPC_STORE, 3'b010, 7'b???????}:  op_dec = exec_pkg::op_sw;
            default:                                    op_dec = exec_pkg::op_nop; // unsupported
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst || flush || (stall && !mem_wait)) begin // bubble
            op    <= exec_pkg::op_nop;
            pc_q  <= '0;
            rd_q  <= '0;
            rs1_q <= '0;
            rs2_q <= '0;
            imm_q <= '0;
        end else if (!mem_wait) begin
            op    <= op_dec;
            pc_q  <= pc;
            rd_q  <= rd_addr;
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
            imm_q <= imm;
        end
    end

    a_nop_after_rst: assert property (@(posedge CLK) rst |=> op == exec_pkg::op_nop);

    // frozen stage keeps its operation for the memory side
    a_hold_on_wait: assert property (@(posedge CLK)
        (mem_wait && !flush && !rst) |=> $stable(op));

endmodule

`default_nettype wire

//--- verilog/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire exec_pkg::op_e                op,
    input  wire  [exec_pkg::XLEN-1:0]         pc_q,
    input  wire  [exec_pkg::XLEN-1:0]         rs1_q,
    input  wire  [exec_pkg::XLEN-1:0]         rs2_q,
    input  wire  [exec_pkg::XLEN-1:0]         imm_q,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]   rd_q,
    output logic                              reg_w_en,
    output logic [exec_pkg::REG_ADDR_W-1:0]   reg_w_rd,
    output logic [exec_pkg::XLEN-1:0]         reg_w_data
);

    logic                          use_imm;
    logic [exec_pkg::XLEN-1:0]     imm_i;
    logic [exec_pkg::XLEN-1:0]     opb;
    logic [exec_pkg::SHAMT_W-1:0]  shamt;
    logic [exec_pkg::XLEN-1:0]     upper;

    assign use_imm = op inside {exec_pkg::op_addi, exec_pkg::op_andi, exec_pkg::op_ori,
                                exec_pkg::op_xori, exec_pkg::op_slli, exec_pkg::op_srli,
                                exec_pkg::op_srai, exec_pkg::op_slti, exec_pkg::op_sltiu};

    assign imm_i = {{(exec_pkg::XLEN-12){imm_q[11]}}, imm_q[11:0]};
    assign opb   = use_imm ? imm_i : rs2_q;
    assign shamt = opb[exec_pkg::SHAMT_W-1:0];
    assign upper = {imm_q[exec_pkg::XLEN-1:12], 12'b0}; // u-type value

    always_comb begin
        reg_w_en   = 1'b1;
        reg_w_rd   = rd_q;
        reg_w_data = '0;
        case (op)
            exec_pkg::op_add, exec_pkg::op_addi:   reg_w_data = rs1_q + opb;
            exec_pkg::op_sub:                      reg_w_data = rs1_q - opb;
            exec_pkg::op_and, exec_pkg::op_andi:   reg_w_data = rs1_q & opb;
            exec_pkg::op_or, exec_pkg::op_ori:     reg_w_data = rs1_q | opb;
            exec_pkg::op_xor, exec_pkg::op_xori:   reg_w_data = rs1_q ^ opb;
            exec_pkg::op_sll, exec_pkg::op_slli:   reg_w_data = rs1_q << shamt;
            exec_pkg::op_srl, exec_pkg::op_srli:   reg_w_data = rs1_q >> shamt;
            exec_pkg::op_sra, exec_pkg::op_srai:   reg_w_data = $signed(rs1_q) >>> shamt;
            exec_pkg::op_slt, exec_pkg::op_slti:
                reg_w_data = {{(exec_pkg::XLEN-1){1'b0}}, $signed(rs1_q) < $signed(opb)};
            exec_pkg::op_sltu, exec_pkg::op_sltiu:
                reg_w_data = {{(exec_pkg::XLEN-1){1'b0}}, rs1_q < opb};
            exec_pkg::op_lui:                      reg_w_data = upper;
            exec_pkg::op_auipc:                    reg_w_data = pc_q + upper;
            exec_pkg::op_jal, exec_pkg::op_jalr:   reg_w_data = pc_q + exec_pkg::LINK_OFFSET;
            exec_pkg::op_lb, exec_pkg::op_lh, exec_pkg::op_lw,
            exec_pkg::op_lbu, exec_pkg::op_lhu: begin
                reg_w_en = 1'b0; // written back by the memory side
            end
            default: begin
                reg_w_en = 1'b0;
                reg_w_rd = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exec_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exec_branch (
    input  wire exec_pkg::op_e            op,
    input  wire  [exec_pkg::XLEN-1:0]     pc_q,
    input  wire  [exec_pkg::XLEN-1:0]     rs1_q,
    input  wire  [exec_pkg::XLEN-1:0]     rs2_q,
    input  wire  [exec_pkg::XLEN-1:0]     imm_q,
    output logic                          jmp_do,
    output logic [exec_pkg::XLEN-1:0]     jmp_pc
);

    logic [exec_pkg::XLEN-1:0] pc_rel;
    logic [exec_pkg::XLEN-1:0] reg_rel;

    assign pc_rel  = pc_q + {{(exec_pkg::XLEN-13){imm_q[12]}}, imm_q[12:1], 1'b0};
    assign reg_rel = rs1_q + {{(exec_pkg::XLEN-12){imm_q[11]}}, imm_q[11:0]};

    always_comb begin
        jmp_do = 1'b0;
        jmp_pc = '0;
        case (op)
            exec_pkg::op_beq:  jmp_do = rs1_q == rs2_q;
            exec_pkg::op_bne:  jmp_do = rs1_q != rs2_q;
            exec_pkg::op_blt:  jmp_do = $signed(rs1_q) < $signed(rs2_q);
            exec_pkg::op_bge:  jmp_do = $signed(rs1_q) >= $signed(rs2_q);
            exec_pkg::op_bltu: jmp_do = rs1_q < rs2_q;
            exec_pkg::op_bgeu: jmp_do = rs1_q >= rs2_q;
            exec_pkg::op_jal:  jmp_do = 1'b1;
            exec_pkg::op_jalr: jmp_do = 1'b1;
            default:           jmp_do = 1'b0;
        endcase
        if (jmp_do) begin
            jmp_pc = (op == exec_pkg::op_jalr) ? {reg_rel[exec_pkg::XLEN-1:1], 1'b0} : pc_rel;
        end
    end

    // pc from fetch must stay halfword aligned
    a_target_aligned: assert final (!jmp_do || !jmp_pc[0]);

endmodule

`default_nettype wire

//--- verilog/exec_mem.sv
`timescale 1ns/1ps
`default_nettype none

module exec_mem (
    input  wire exec_pkg::op_e                op,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]   rd_q,
    input  wire  [exec_pkg::XLEN-1:0]         rs1_q,
    input  wire  [exec_pkg::XLEN-1:0]         rs2_q,
    input  wire  [exec_pkg::XLEN-1:0]         imm_q,
    output logic                              mem_r_en,
    output logic [exec_pkg::REG_ADDR_W-1:0]   mem_r_rd,
    output logic [exec_pkg::XLEN-1:0]         mem_r_addr,
    output logic [exec_pkg::STRB_W-1:0]       mem_r_strb,
    output logic                              mem_r_signed,
    output logic                              mem_w_en,
    output logic [exec_pkg::XLEN-1:0]         mem_w_addr,
    output logic [exec_pkg::STRB_W-1:0]       mem_w_strb,
    output logic [exec_pkg::XLEN-1:0]         mem_w_data
);

    logic [exec_pkg::XLEN-1:0] eff_addr;

    assign eff_addr = rs1_q + {{(exec_pkg::XLEN-12){imm_q[11]}}, imm_q[11:0]};

    always_comb begin
        mem_r_en     = 1'b0;
        mem_r_rd     = '0;
        mem_r_addr   = '0;
        mem_r_strb   = '0;
        mem_r_signed = 1'b0;
        case (op)
            exec_pkg::op_lb, exec_pkg::op_lbu:   mem_r_strb = exec_pkg::STRB_BYTE;
            exec_pkg::op_lh, exec_pkg::op_lhu:   mem_r_strb = exec_pkg::STRB_HALF;
            exec_pkg::op_lw:                     mem_r_strb = exec_pkg::STRB_WORD;
            default:                             mem_r_strb = '0;
        endcase
        if (mem_r_strb != '0) begin // any load
            mem_r_en     = 1'b1;
            mem_r_rd     = rd_q;
            mem_r_addr   = eff_addr;
            mem_r_signed = op inside {exec_pkg::op_lb, exec_pkg::op_lh};
        end
    end

    always_comb begin
        mem_w_en   = 1'b0;
        mem_w_addr = '0;
        mem_w_data = '0;
        case (op)
            exec_pkg::op_sb: mem_w_strb = exec_pkg::STRB_BYTE;
            exec_pkg::op_sh: mem_w_strb = exec_pkg::STRB_HALF;
            exec_pkg::op_sw: mem_w_strb = exec_pkg::STRB_WORD;
            default:         mem_w_strb = '0;
        endcase
        if (mem_w_strb != '0) begin
            mem_w_en   = 1'b1;
            mem_w_addr = eff_addr;
            mem_w_data = rs2_q;
        end
    end

    a_one_request: assert final (!(mem_r_en && mem_w_en));

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                               CLK,
    input  wire                               rst,
    input  wire                               flush,
    input  wire                               stall,
    input  wire                               mem_wait,
    input  wire  [exec_pkg::XLEN-1:0]         pc,
    input  wire  [exec_pkg::OPCODE_W-1:0]     opcode,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]   rd_addr,
    input  wire  [exec_pkg::XLEN-1:0]         rs1_data,
    input  wire  [exec_pkg::XLEN-1:0]         rs2_data,
    input  wire  [exec_pkg::XLEN-1:0]         imm,
    output wire                               reg_w_en,
    output wire  [exec_pkg::REG_ADDR_W-1:0]   reg_w_rd,
    output wire  [exec_pkg::XLEN-1:0]         reg_w_data,
    output wire                               mem_r_en,
    output wire  [exec_pkg::REG_ADDR_W-1:0]   mem_r_rd,
    output wire  [exec_pkg::XLEN-1:0]         mem_r_addr,
    output wire  [exec_pkg::STRB_W-1:0]       mem_r_strb,
    output wire                               mem_r_signed,
    output wire                               mem_w_en,
    output wire  [exec_pkg::XLEN-1:0]         mem_w_addr,
    output wire  [exec_pkg::STRB_W-1:0]       mem_w_strb,
    output wire  [exec_pkg::XLEN-1:0]         mem_w_data,
    output wire                               jmp_do,
    output wire  [exec_pkg::XLEN-1:0]         jmp_pc
);

    wire exec_pkg::op_e                op;
    wire [exec_pkg::XLEN-1:0]          pc_q;
    wire [exec_pkg::REG_ADDR_W-1:0]    rd_q;
    wire [exec_pkg::XLEN-1:0]          rs1_q;
    wire [exec_pkg::XLEN-1:0]          rs2_q;
    wire [exec_pkg::XLEN-1:0]          imm_q;

    exec_latch i_exec_latch (
        .CLK(CLK), .rst(rst), .flush(flush), .stall(stall), .mem_wait(mem_wait),
        .pc(pc), .opcode(opcode), .rd_addr(rd_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .op(op), .pc_q(pc_q), .rd_q(rd_q), .rs1_q(rs1_q), .rs2_q(rs2_q), .imm_q(imm_q)
    );

    exec_alu i_exec_alu (
        .op(op), .pc_q(pc_q), .rs1_q(rs1_q), .rs2_q(rs2_q), .imm_q(imm_q), .rd_q(rd_q),
        .reg_w_en(reg_w_en), .reg_w_rd(reg_w_rd), .reg_w_data(reg_w_data)
    );

    exec_branch i_exec_branch (
        .op(op), .pc_q(pc_q), .rs1_q(rs1_q), .rs2_q(rs2_q), .imm_q(imm_q),
        .jmp_do(jmp_do), .jmp_pc(jmp_pc)
    );

    exec_mem i_exec_mem (
        .op(op), .rd_q(rd_q), .rs1_q(rs1_q), .rs2_q(rs2_q), .imm_q(imm_q),
        .mem_r_en(mem_r_en), .mem_r_rd(mem_r_rd), .mem_r_addr(mem_r_addr),
        .mem_r_strb(mem_r_strb), .mem_r_signed(mem_r_signed),
        .mem_w_en(mem_w_en), .mem_w_addr(mem_w_addr),
        .mem_w_strb(mem_w_strb), .mem_w_data(mem_w_data)
    );

endmodule

`default_nettype wire

//--- bench/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input  wire          CLK,
    input  wire          check_en,
    input  wire          exp_rwen,
    input  wire  [31:0]  exp_rwdata,
    input  wire          exp_rden,
    input  wire  [31:0]  exp_raddr,
    input  wire  [3:0]   exp_rstrb,
    input  wire          exp_rsign,
    input  wire          exp_wen,
    input  wire  [31:0]  exp_wdata,
    input  wire          exp_jdo,
    input  wire  [31:0]  exp_jpc,
    input  wire  [4:0]   exp_wrd,
    input  wire  [4:0]   exp_rrd,
    input  wire  [31:0]  exp_waddr,
    input  wire  [3:0]   exp_wstrb,
    input  wire          reg_w_en,
    input  wire  [31:0]  reg_w_data,
    input  wire          mem_r_en,
    input  wire  [31:0]  mem_r_addr,
    input  wire  [3:0]   mem_r_strb,
    input  wire          mem_r_signed,
    input  wire          mem_w_en,
    input  wire  [31:0]  mem_w_data,
    input  wire          jmp_do,
    input  wire  [31:0]  jmp_pc,
    input  wire  [4:0]   reg_w_rd,
    input  wire  [4:0]   mem_r_rd,
    input  wire  [31:0]  mem_w_addr,
    input  wire  [3:0]   mem_w_strb,
    output int           check_count,
    output int           error_count
);

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare_field(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            error_count++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    // outputs are stable mid-cycle
    always @(negedge CLK) begin
        if (check_en) begin
            compare_field("reg_w_en", exp_rwen, reg_w_en);
            compare_field("reg_w_rd", exp_wrd, reg_w_rd);
            compare_field("reg_w_data", exp_rwdata, reg_w_data);
            compare_field("mem_r_en", exp_rden, mem_r_en);
            compare_field("mem_r_rd", exp_rrd, mem_r_rd);
            compare_field("mem_r_addr", exp_raddr, mem_r_addr);
            compare_field("mem_r_strb", exp_rstrb, mem_r_strb);
            compare_field("mem_r_signed", exp_rsign, mem_r_signed);
            compare_field("mem_w_en", exp_wen, mem_w_en);
            compare_field("mem_w_addr", exp_waddr, mem_w_addr);
            compare_field("mem_w_strb", exp_wstrb, mem_w_strb);
            compare_field("mem_w_data", exp_wdata, mem_w_data);
            compare_field("jmp_do", exp_jdo, jmp_do);
            compare_field("jmp_pc", exp_jpc, jmp_pc);
            check_count++;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    logic                               CLK;
    logic                               rst;
    logic                               flush;
    logic                               stall;
    logic                               mem_wait;
    logic [exec_pkg::XLEN-1:0]          pc;
    logic [exec_pkg::OPCODE_W-1:0]      opcode;
    logic [exec_pkg::REG_ADDR_W-1:0]    rd_addr;
    logic [exec_pkg::XLEN-1:0]          rs1_data;
    logic [exec_pkg::XLEN-1:0]          rs2_data;
    logic [exec_pkg::XLEN-1:0]          imm;

    wire                                reg_w_en;
    wire  [exec_pkg::REG_ADDR_W-1:0]    reg_w_rd;
    wire  [exec_pkg::XLEN-1:0]          reg_w_data;
    wire                                mem_r_en;
    wire  [exec_pkg::REG_ADDR_W-1:0]    mem_r_rd;
    wire  [exec_pkg::XLEN-1:0]          mem_r_addr;
    wire  [exec_pkg::STRB_W-1:0]        mem_r_strb;
    wire                                mem_r_signed;
    wire                                mem_w_en;
    wire  [exec_pkg::XLEN-1:0]          mem_w_addr;
    wire  [exec_pkg::STRB_W-1:0]        mem_w_strb;
    wire  [exec_pkg::XLEN-1:0]          mem_w_data;
    wire                                jmp_do;
    wire  [exec_pkg::XLEN-1:0]          jmp_pc;

    // expectations handed to the checker
    logic        check_en;
    logic        exp_rwen, exp_rden, exp_rsign, exp_wen, exp_jdo;
    logic [31:0] exp_rwdata, exp_raddr, exp_wdata, exp_jpc;
    logic [3:0]  exp_rstrb;
    logic [4:0]  exp_wrd, exp_rrd;
    logic [31:0] exp_waddr;
    logic [3:0]  exp_wstrb;
    int          check_count;
    int          error_count;

    exec_stage i_exec_stage (
        .CLK(CLK), .rst(rst), .flush(flush), .stall(stall), .mem_wait(mem_wait),
        .pc(pc), .opcode(opcode), .rd_addr(rd_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .reg_w_en(reg_w_en), .reg_w_rd(reg_w_rd), .reg_w_data(reg_w_data),
        .mem_r_en(mem_r_en), .mem_r_rd(mem_r_rd), .mem_r_addr(mem_r_addr),
        .mem_r_strb(mem_r_strb), .mem_r_signed(mem_r_signed),
        .mem_w_en(mem_w_en), .mem_w_addr(mem_w_addr),
        .mem_w_strb(mem_w_strb), .mem_w_data(mem_w_data),
        .jmp_do(jmp_do), .jmp_pc(jmp_pc)
    );

    exec_checker i_exec_checker (
        .CLK(CLK), .check_en(check_en),
        .exp_rwen(exp_rwen), .exp_rwdata(exp_rwdata), .exp_rden(exp_rden),
        .exp_raddr(exp_raddr), .exp_rstrb(exp_rstrb), .exp_rsign(exp_rsign),
        .exp_wen(exp_wen), .exp_wdata(exp_wdata), .exp_jdo(exp_jdo), .exp_jpc(exp_jpc),
        .exp_wrd(exp_wrd), .exp_rrd(exp_rrd), .exp_waddr(exp_waddr), .exp_wstrb(exp_wstrb),
        .reg_w_en(reg_w_en), .reg_w_data(reg_w_data), .mem_r_en(mem_r_en),
        .mem_r_addr(mem_r_addr), .mem_r_strb(mem_r_strb), .mem_r_signed(mem_r_signed),
        .mem_w_en(mem_w_en), .mem_w_data(mem_w_data), .jmp_do(jmp_do), .jmp_pc(jmp_pc),
        .reg_w_rd(reg_w_rd), .mem_r_rd(mem_r_rd), .mem_w_addr(mem_w_addr),
        .mem_w_strb(mem_w_strb),
        .check_count(check_count), .error_count(error_count)
    );

    // byte lanes touched by an access of the size in funct3
    function automatic logic [3:0] access_strobe(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00:   return 4'b0001;
            2'b01:   return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK; // 4 ns period
    end

    // hard limit on the whole run
    initial begin
        #200000;
        $display("simulation time limit reached before the run finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n_fields;
        int          n_vec;
        int          n_expected;
        int          wait_cycles;
        int          imm_ofs;
        reg [8*256-1:0] line;
        logic        v_fl, v_st, v_mw;
        logic [31:0] v_pc, v_rs1, v_rs2, v_imm;
        logic [16:0] v_opc;
        logic [4:0]  v_rd;
        logic        e_rwen, e_rden, e_rsign, e_wen, e_jdo;
        logic [31:0] e_rwdata, e_raddr, e_wdata, e_jpc;
        logic [3:0]  e_rstrb;
        logic [4:0]  held_rd;
        logic [31:0] held_waddr;
        logic [3:0]  held_wstrb;

        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        mem_wait = 1'b0;
        pc = '0;
        opcode = '0;
        rd_addr = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        check_en = 1'b0;
        {exp_rwen, exp_rden, exp_rsign, exp_wen, exp_jdo} = '0;
        {exp_rwdata, exp_raddr, exp_wdata, exp_jpc, exp_rstrb} = '0;
        {exp_wrd, exp_rrd, exp_waddr, exp_wstrb} = '0;
        held_rd = '0;
        held_waddr = '0;
        held_wstrb = '0;
        n_vec = 0;

        fd = $fopen("bench/exec_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/exec_stim.txt");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (4) @(posedge CLK);
            check_en = 1'b1; // reset state seen on the next falling edge
            @(negedge CLK);
            rst = 1'b0;
            while (!$feof(fd)) begin
                line = '0;
                n_fields = $fgets(line, fd);
                n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v_fl, v_st, v_mw, v_pc, v_opc, v_rd, v_rs1, v_rs2, v_imm,
                    e_rwen, e_rwdata, e_rden, e_raddr, e_rstrb, e_rsign,
                    e_wen, e_wdata, e_jdo, e_jpc);
                if (n_fields == 19) begin // comment and blank lines skipped
                    @(negedge CLK);
                    flush = v_fl;
                    stall = v_st;
                    mem_wait = v_mw;
                    pc = v_pc;
                    opcode = v_opc;
                    rd_addr = v_rd;
                    rs1_data = v_rs1;
                    rs2_data = v_rs2;
                    imm = v_imm;
                    if (v_fl || !v_mw) begin // mem_wait keeps the older instruction
                        imm_ofs = $signed(v_imm[11:0]);
                        held_rd = v_rd;
                        held_waddr = v_rs1 + imm_ofs;
                        held_wstrb = access_strobe(v_opc[9:7]);
                    end
                    @(posedge CLK);
                    exp_rwen = e_rwen;
                    exp_rwdata = e_rwdata;
                    exp_rden = e_rden;
                    exp_raddr = e_raddr;
                    exp_rstrb = e_rstrb;
                    exp_rsign = e_rsign;
                    exp_wen = e_wen;
                    exp_wdata = e_wdata;
                    exp_jdo = e_jdo;
                    exp_jpc = e_jpc;
                    exp_wrd = (e_rwen || e_rden) ? held_rd : '0;
                    exp_rrd = e_rden ? held_rd : '0;
                    exp_waddr = e_wen ? held_waddr : '0;
                    exp_wstrb = e_wen ? held_wstrb : '0;
                    n_vec++;
                end
            end
            $fclose(fd);
            n_expected = n_vec + 2; // both bubbles around reset release

            // drain until the checker has seen every vector
            wait_cycles = 0;
            while (check_count < n_expected && wait_cycles < 20) begin
                @(posedge CLK);
                wait_cycles++;
            end
            check_en = 1'b0;
            if (check_count < n_expected) begin
                $display("timeout waiting for the checker to compare the last vector");
            end
            $display("checks %0d, errors %0d", check_count, error_count);
            if (error_count == 0 && check_count == n_expected && n_vec > 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/exec_stim.txt
# fl st mw pc opcode rd rs1 rs2 imm | rwen rwdata rden raddr rstrb rsign wen wdata jdo jpc
# all hex; expected columns hold the outputs one cycle after the vector is applied
0 0 0 00001000 0cc00 05 00000007 00000005 00000000 1 0000000c 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cc20 05 00000005 00000007 00000000 1 fffffffe 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cf80 05 f0f0ff00 0ff00ff0 00000000 1 00f00f00 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cf00 05 f0f0ff00 0ff00ff0 00000000 1 fff0fff0 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0ce00 05 f0f0ff00 0ff00ff0 00000000 1 ff00f0f0 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04c00 05 00000010 12345678 00000ff0 1 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04f80 05 12345678 00000000 000000ff 1 00000078 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04f00 05 12345600 00000000 0000007f 1 1234567f 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04e00 05 0000ffff 00000000 00000fff 1 ffff0000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cc80 05 00000003 00000024 00000000 1 00000030 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0ce80 05 80000000 0000001f 00000000 1 00000001 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cea0 05 80000000 00000004 00000000 1 f8000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04c80 05 00000001 00000000 0000001f 1 80000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04e80 05 ffffffff 00000000 00000004 1 0fffffff 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04ea0 05 fffffff0 00000000 00000002 1 fffffffc 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cd00 05 ffffffff 00000001 00000000 1 00000001 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cd80 05 ffffffff 00000001 00000000 1 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 04d80 05 00000005 00000000 00000fff 1 00000001 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0dc00 05 00000000 00000000 12345abc 1 12345000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 05c00 05 00000000 00000000 00002fff 1 00003000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 00c00 05 00002000 00000000 00000ffc 0 00000000 1 00001ffc 1 1 0 00000000 0 00000000
0 0 0 00001000 00e80 05 00002000 00000000 00000006 0 00000000 1 00002006 3 0 0 00000000 0 00000000
0 0 0 00001000 08c00 00 00004000 000000aa 00000001 0 00000000 0 00000000 0 0 1 000000aa 0 00000000
0 0 0 00001000 08d00 00 00004000 deadbeef 00000008 0 00000000 0 00000000 0 0 1 deadbeef 0 00000000
0 0 0 00001000 18c00 00 00000005 00000005 00000010 0 00000000 0 00000000 0 0 0 00000000 1 00001010
0 0 0 00001000 18c00 00 00000005 00000006 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 18c80 00 00000005 00000006 00001ff8 0 00000000 0 00000000 0 0 0 00000000 1 00000ff8
0 0 0 00001000 18c80 00 00000005 00000005 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 18e00 00 ffffffff 00000001 00000010 0 00000000 0 00000000 0 0 0 00000000 1 00001010
0 0 0 00001000 18e00 00 00000001 ffffffff 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 18e80 00 00000001 ffffffff 00000010 0 00000000 0 00000000 0 0 0 00000000 1 00001010
0 0 0 00001000 18e80 00 ffffffff 00000001 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 18f00 00 00000001 ffffffff 00000010 0 00000000 0 00000000 0 0 0 00000000 1 00001010
0 0 0 00001000 18f00 00 ffffffff 00000001 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 18f80 00 ffffffff 00000001 00000010 0 00000000 0 00000000 0 0 0 00000000 1 00001010
0 0 0 00001000 18f80 00 00000001 ffffffff 00000010 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 1bc00 01 00000000 00000000 00000100 1 00001004 0 00000000 0 0 0 00000000 1 00001100
0 0 0 00002000 19c00 01 00003001 00000000 00000004 1 00002004 0 00000000 0 0 0 00000000 1 00003004
0 1 0 00001000 0cc00 05 00000007 00000005 00000000 0 00000000 0 00000000 0 0 0 00000000 0 00000000
1 0 0 00001000 0cc00 05 00000007 00000005 00000000 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 00d00 05 00003000 00000000 00000010 0 00000000 1 00003010 f 0 0 00000000 0 00000000
0 0 1 00001000 0cc00 05 00000007 00000005 00000000 0 00000000 1 00003010 f 0 0 00000000 0 00000000
0 1 1 00001000 0cc00 05 00000007 00000005 00000000 0 00000000 1 00003010 f 0 0 00000000 0 00000000
0 0 0 00001000 1fc00 05 00000007 00000005 00000000 0 00000000 0 00000000 0 0 0 00000000 0 00000000
0 0 0 00001000 0cc01 05 00000007 00000005 00000000 0 00000000 0 00000000 0 0 0 00000000 0 00000000

//--- compile.f
verilog/exec_pkg.sv
verilog/exec_latch.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_mem.sv
verilog/exec_stage.sv
bench/exec_checker.sv
bench/tb_exec_stage.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - verilog/exec_pkg.sv
  - verilog/exec_latch.sv
  - verilog/exec_alu.sv
  - verilog/exec_branch.sv
  - verilog/exec_mem.sv
  - verilog/exec_stage.sv
  - target: test
    files:
      - bench/exec_checker.sv
      - bench/tb_exec_stage.sv
